/* files.f */
+incdir+.
dcache_pkg.sv
dcache_ifs.sv
dcache_store.sv
dcache_lookup.sv
dcache_miss_unit.sv
dcache_top.sv
dcache_assertions.sv
tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
# build the dcache testbench with verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_dcache -f files.f -o tb_dcache \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_dcache > sim.log 2>&1
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && { echo "simulation failed"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log || { echo "no pass message in sim.log"; exit 1; }
exit 0

/* tb_dcache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dcache
    import dcache_pkg::*;
();

    localparam addr_t LINE_A      = 32'h0000_2040;
    localparam addr_t LINE_B      = 32'h0000_3080;
    localparam addr_t LINE_C      = 32'h0001_0050;
    localparam addr_t STREAM_BASE = 32'h0002_0100;
    localparam int    SET_STRIDE  = 1024;
    localparam int    STREAM_LEN  = 40;
    localparam int    MEM_LAT     = 3;
    localparam int    N_REQ       = 1 + 3 + 6 + 2 + 6 + STREAM_LEN;

    logic  clk = 1'b0;
    logic  rst = 1'b1;
    logic  req_valid_i = 1'b0;
    logic  req_ready_o;
    addr_t req_addr_i = '0;
    strb_t req_wstrb_i = '0;
    word_t req_wdata_i = '0;
    logic  resp_valid_o;
    word_t resp_rdata_o;
    logic  mem_req_valid_o;
    logic  mem_req_ready_i = 1'b0;
    logic  mem_req_we_o;
    addr_t mem_req_addr_o;
    line_t mem_req_wdata_o;
    logic  mem_resp_valid_i = 1'b0;
    line_t mem_resp_rdata_i = '0;

    integer seed = 32'h9e37_1690;
    integer stim_seed = 32'h9e37_1690;
    int     mon_errors = 0;
    int     test_errors = 0;
    int     rd_count = 0;
    int     wb_count = 0;
    int     rd_wait = 0;
    addr_t  rd_addr = '0;
    logic   acc_valid = 1'b0;
    logic   acc_we = 1'b0;
    addr_t  acc_addr = '0;

    // requests accepted but not yet answered, oldest first
    addr_t  q_addr [$];
    strb_t  q_strb [$];
    word_t  q_wdata [$];
    word_t  shadow [addr_t];
    line_t  mem_lines [addr_t];

    dcache_top i_dut (.*);

    always #4 clk = ~clk;

    function automatic word_t shadow_word(input addr_t a);
        addr_t wa;
        wa = {a[31:2], 2'b00};
        if (shadow.exists(wa)) return shadow[wa];
        return wa ^ 32'h5a5a_0000;
    endfunction

    function automatic line_t shadow_line(input addr_t a);
        line_t l;
        for (int i = 0; i < 4; i++) l[i*32 +: 32] = shadow_word(a + addr_t'(i * 4));
        return l;
    endfunction

    // untouched memory holds its own byte address xor a constant
    function automatic line_t mem_line(input addr_t a);
        line_t l;
        if (mem_lines.exists(a)) return mem_lines[a];
        for (int i = 0; i < 4; i++) l[i*32 +: 32] = (a + addr_t'(i * 4)) ^ 32'h5a5a_0000;
        return l;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            mon_errors++;
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            mon_errors++;
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic expect_count(input string what, input int got, input int exp);
        if (got != exp) begin
            test_errors++;
            $display("%s: expected %0d, saw %0d", what, exp, got);
        end
    endtask

    // everything seen on the DUT outputs is sampled mid-cycle
    always @(negedge clk) begin : monitor
        addr_t a;
        strb_t s;
        word_t d;
        word_t w;
        acc_valid = !rst && mem_req_valid_o && mem_req_ready_i;
        acc_we    = mem_req_we_o;
        acc_addr  = mem_req_addr_o;
        if (!rst && resp_valid_o) begin
            if (q_addr.size() == 0) begin
                mon_errors++;
                $display("response at %0t without any request outstanding", $time);
            end else begin
                a = q_addr.pop_front();
                s = q_strb.pop_front();
                d = q_wdata.pop_front();
                if (s == '0) begin
                    check_word("resp_rdata_o", resp_rdata_o, shadow_word(a));
                end else begin
                    check_word("resp_rdata_o", resp_rdata_o, '0);
                    w = shadow_word(a);
                    for (int b = 0; b < 4; b++) if (s[b]) w[b*8 +: 8] = d[b*8 +: 8];
                    shadow[{a[31:2], 2'b00}] = w;
                end
            end
        end
        if (acc_valid && acc_we) begin
            wb_count++;
            check_line("mem_req_wdata_o", mem_req_wdata_o, shadow_line(mem_req_addr_o));
            mem_lines[mem_req_addr_o] = mem_req_wdata_o;
        end else if (acc_valid) begin
            rd_count++;
        end
        if (!rst && req_valid_i && req_ready_o) begin
            q_addr.push_back(req_addr_i);
            q_strb.push_back(req_wstrb_i);
            q_wdata.push_back(req_wdata_i);
        end
    end

    always @(posedge clk) begin : mem_model
        mem_req_ready_i  <= (($random(seed) & 3) != 0);
        mem_resp_valid_i <= 1'b0;
        if (rd_wait != 0) begin
            rd_wait = rd_wait - 1;
            if (rd_wait == 0) begin
                mem_resp_valid_i <= 1'b1;
                mem_resp_rdata_i <= mem_line(rd_addr);
            end
        end
        if (acc_valid && !acc_we) begin
            rd_wait = MEM_LAT;
            rd_addr = acc_addr;
        end
    end

    // called on a rising edge, returns on the edge that accepts the request
    task automatic issue(input addr_t addr, input strb_t strb, input word_t data);
        req_valid_i <= 1'b1;
        req_addr_i  <= addr;
        req_wstrb_i <= strb;
        req_wdata_i <= data;
        do begin
            @(negedge clk);
        end while (!req_ready_o);
        @(posedge clk);
        req_valid_i <= 1'b0;
    endtask

    task automatic drain();
        while (q_addr.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic access(input addr_t addr, input strb_t strb, input word_t data);
        issue(addr, strb, data);
        drain();
    endtask

    task automatic test_first_load();
        int rd0;
        rd0 = rd_count;
        access(LINE_A, 4'b0000, '0);
        expect_count("memory reads for the first load", rd_count - rd0, 1);
    endtask

    task automatic test_same_line();
        int n0;
        n0 = rd_count + wb_count;
        access(LINE_A + 32'd4, 4'b0000, '0);
        access(LINE_A + 32'd8, 4'b0000, '0);
        access(LINE_A + 32'd12, 4'b0000, '0);
        expect_count("memory requests for a present line", rd_count + wb_count - n0, 0);
    endtask

    task automatic test_store_hit();
        int n0;
        n0 = rd_count + wb_count;
        access(LINE_A + 32'd4, 4'b0100, 32'h1122_3344);
        access(LINE_A + 32'd4, 4'b0000, '0);
        access(LINE_A + 32'd8, 4'b1100, 32'hcafe_0000);
        access(LINE_A + 32'd8, 4'b0000, '0);
        access(LINE_A, 4'b1111, 32'hdead_beef);
        access(LINE_A, 4'b0000, '0);
        expect_count("memory requests for stores that hit", rd_count + wb_count - n0, 0);
    endtask

    task automatic test_store_miss();
        int rd0;
        rd0 = rd_count;
        access(LINE_B + 32'd8, 4'b0010, 32'h0000_a500);
        access(LINE_B + 32'd8, 4'b0000, '0);
        expect_count("memory reads for a store miss", rd_count - rd0, 1);
    endtask

    // three dirty lines cannot share a two-way set
    task automatic test_evict();
        int wb0;
        wb0 = wb_count;
        for (int k = 0; k < 3; k++) begin
            access(LINE_C + addr_t'(k * SET_STRIDE), 4'b1111, word_t'(32'h7000_0000 + k));
        end
        if (wb_count == wb0) begin
            test_errors++;
            $display("no write-back after three dirty lines in one set");
        end
        for (int k = 0; k < 3; k++) begin
            access(LINE_C + addr_t'(k * SET_STRIDE), 4'b0000, '0);
        end
    endtask

    task automatic test_stream();
        int    set_bit;
        int    tag;
        int    wsel;
        int    kind;
        addr_t a;
        strb_t s;
        word_t d;
        for (int i = 0; i < STREAM_LEN; i++) begin
            set_bit = $random(stim_seed) & 1;
            tag     = $random(stim_seed) & 3;
            wsel    = $random(stim_seed) & 3;
            kind    = $random(stim_seed) & 3;
            a = STREAM_BASE + addr_t'(set_bit * 16 + tag * SET_STRIDE + wsel * 4);
            case (kind)
                0: s = 4'b0000;
                1: s = strb_t'(1 << ($random(stim_seed) & 3));
                2: s = (($random(stim_seed) & 1) != 0) ? 4'b1100 : 4'b0011;
                default: s = 4'b1111;
            endcase
            d = $random(stim_seed);
            issue(a, s, d);
        end
        drain();
    endtask

    initial begin : watchdog
        #((3 + 64 + 200 * N_REQ) * 8);
        $display("timeout at %0t, %0d responses missing", $time, q_addr.size());
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : main
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        do begin
            @(negedge clk);
        end while (!req_ready_o);
        @(posedge clk);
        test_first_load();
        test_same_line();
        test_store_hit();
        test_store_miss();
        test_evict();
        test_stream();
        $display("errors: %0d in responses and memory traffic, %0d in request counts",
                 mon_errors, test_errors);
        if (mon_errors == 0 && test_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dcache_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_assertions
    import dcache_pkg::*;
(
    input  wire    clk,
    input  wire    rst,
    input  wire    req_valid_i,
    input  wire    req_ready_o,
    input  wire    resp_valid_o,
    input  wire    mem_req_valid_o,
    input  wire    mem_req_ready_i,
    input  wire    mem_req_we_o,
    input  addr_t  mem_req_addr_o,
    input  line_t  mem_req_wdata_o
);

    // accepted requests still waiting for their response
    logic [2:0] outstanding;

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + 3'(req_valid_i && req_ready_o) - 3'(resp_valid_o);
        end
    end

    mem_req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_we_o)
            && $stable(mem_req_addr_o) && $stable(mem_req_wdata_o))
        else $error("memory request changed while stalled");

    resp_has_req: assert property (@(posedge clk) disable iff (rst)
        resp_valid_o |-> outstanding != 3'd0)
        else $error("response without an outstanding request");

    no_accept_on_mem: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid_o |-> !req_ready_o)
        else $error("request port ready during a memory request");

endmodule

bind dcache_top dcache_assertions i_assertions (.*);

`default_nettype wire

/* dcache_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  wire    clk,
    input  wire    rst,
    input  wire    req_valid_i,
    output logic   req_ready_o,
    input  addr_t  req_addr_i,
    input  strb_t  req_wstrb_i,
    input  word_t  req_wdata_i,
    output logic   resp_valid_o,
    output word_t  resp_rdata_o,
    output logic   mem_req_valid_o,
    input  wire    mem_req_ready_i,
    output logic   mem_req_we_o,
    output addr_t  mem_req_addr_o,
    output line_t  mem_req_wdata_o,
    input  wire    mem_resp_valid_i,
    input  line_t  mem_resp_rdata_i
);

    index_t                        rd_index;
    tag_entry_t [`DCACHE_NWAY-1:0] rd_entry;
    line_t [`DCACHE_NWAY-1:0]      rd_line;
    logic                          init_done;

    array_wr_if i_wr_if ();
    miss_if     i_miss_if ();

    dcache_store i_store (
        .clk         (clk),
        .rst         (rst),
        .rd_index_i  (rd_index),
        .wr          (i_wr_if.store),
        .rd_entry_o  (rd_entry),
        .rd_line_o   (rd_line),
        .init_done_o (init_done)
    );

    dcache_lookup i_lookup (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid_i),
        .req_addr_i   (req_addr_i),
        .req_wstrb_i  (req_wstrb_i),
        .req_wdata_i  (req_wdata_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_rdata_o (resp_rdata_o),
        .init_done_i  (init_done),
        .rd_index_o   (rd_index),
        .rd_entry_i   (rd_entry),
        .rd_line_i    (rd_line),
        .wr           (i_wr_if.lookup),
        .miss         (i_miss_if.lookup)
    );

    dcache_miss_unit i_miss_unit (
        .clk              (clk),
        .rst              (rst),
        .miss             (i_miss_if.miss),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_we_o     (mem_req_we_o),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_req_wdata_o  (mem_req_wdata_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_rdata_i (mem_resp_rdata_i)
    );

endmodule

`default_nettype wire

/* dcache_miss_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_miss_unit
    import dcache_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    miss_if.miss        miss,
    output logic        mem_req_valid_o,
    output logic        mem_req_we_o,
    output addr_t       mem_req_addr_o,
    output line_t       mem_req_wdata_o,
    input  wire         mem_req_ready_i,
    input  wire         mem_resp_valid_i,
    input  line_t       mem_resp_rdata_i
);

    localparam int OFF_W = $clog2(`DCACHE_LINE_BYTES);
    localparam int TAG_W = $bits(tag_t);

    miss_state_t               state;
    miss_state_t               state_nxt;
    logic [`DCACHE_LFSR_W-1:0] lfsr_q;
    way_t                      lfsr_way;
    way_t                      victim_way_q;
    way_t                      cur_way;
    tag_entry_t                vic_entry;
    addr_t                     wb_addr;
    addr_t                     refill_addr;

    // x^16 + x^14 + x^13 + x^11, free running
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= {{(`DCACHE_LFSR_W-1){1'b0}}, 1'b1};
        end else begin
            lfsr_q <= {lfsr_q[`DCACHE_LFSR_W-2:0],
                       lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
        end
    end

    assign lfsr_way = lfsr_q[$bits(way_t)-1:0];

    // way is taken from the lfsr only in the cycle the miss starts
    assign cur_way   = (state == MS_IDLE) ? lfsr_way : victim_way_q;
    assign vic_entry = miss.victim_entry[cur_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            victim_way_q <= '0;
        end else if (state == MS_IDLE && miss.miss_valid) begin
            victim_way_q <= lfsr_way;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MS_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            MS_IDLE: begin
                if (miss.miss_valid) begin
                    // dirty and valid victim goes out before the refill
                    if (vic_entry[TAG_W+1] && vic_entry[TAG_W]) begin
                        state_nxt = MS_WB_REQ;
                    end else begin
                        state_nxt = MS_REFILL_REQ;
                    end
                end
            end
            MS_WB_REQ: begin
                if (mem_req_ready_i) begin
                    state_nxt = MS_REFILL_REQ;
                end
            end
            MS_REFILL_REQ: begin
                if (mem_req_ready_i) begin
                    state_nxt = MS_REFILL_WAIT;
                end
            end
            MS_REFILL_WAIT: begin
                if (mem_resp_valid_i) begin
                    state_nxt = MS_IDLE;
                end
            end
            default: begin
                state_nxt = MS_IDLE;
            end
        endcase
    end

    assign wb_addr     = {vic_entry[TAG_W-1:0], miss.miss_addr[OFF_W +: $bits(index_t)],
                          {OFF_W{1'b0}}};
    assign refill_addr = {miss.miss_addr[`DCACHE_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};

    // request fields come from held state only, so they stay stable while not ready
    always_comb begin
        mem_req_valid_o = 1'b0;
        mem_req_we_o    = 1'b0;
        mem_req_addr_o  = refill_addr;
        mem_req_wdata_o = miss.victim_line[cur_way];
        case (state)
            MS_WB_REQ: begin
                mem_req_valid_o = 1'b1;
                mem_req_we_o    = 1'b1;
                mem_req_addr_o  = wb_addr;
            end
            MS_REFILL_REQ: begin
                mem_req_valid_o = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign miss.refill_valid = (state == MS_REFILL_WAIT) && mem_resp_valid_i;
    assign miss.refill_way   = victim_way_q;
    assign miss.refill_line  = mem_resp_rdata_i;

endmodule

`default_nettype wire

/* dcache_lookup.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_lookup
    import dcache_pkg::*;
(
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            req_valid_i,
    input  addr_t                          req_addr_i,
    input  strb_t                          req_wstrb_i,
    input  word_t                          req_wdata_i,
    output logic                           req_ready_o,
    output logic                           resp_valid_o,
    output word_t                          resp_rdata_o,
    input  wire                            init_done_i,
    output index_t                         rd_index_o,
    input  tag_entry_t [`DCACHE_NWAY-1:0]  rd_entry_i,
    input  line_t [`DCACHE_NWAY-1:0]       rd_line_i,
    array_wr_if.lookup                     wr,
    miss_if.lookup                         miss
);

    localparam int OFF_W = $clog2(`DCACHE_LINE_BYTES);
    localparam int TAG_W = $bits(tag_t);

    logic      s1_valid;
    addr_t     s1_addr;
    strb_t     s1_wstrb;
    word_t     s1_wdata;
    logic      s2_valid;
    addr_t     s2_addr;
    strb_t     s2_wstrb;
    word_t     s2_wdata;

    tag_t      s2_tag;
    index_t    s2_index;
    word_sel_t s2_word;
    logic      s2_store;

    way_mask_t  hit_mask;
    way_t       hit_way;
    logic       hit;
    logic       lookup_act;
    logic       hit_now;
    logic       miss_now;
    logic       miss_pend;
    logic       stall;
    line_t      sel_line;
    line_strb_t store_be;
    line_t      store_line;
    line_t      refill_merged;

    assign stall       = s2_valid && (miss_now || (miss_pend && !miss.refill_valid));
    assign req_ready_o = init_done_i && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= req_valid_i && req_ready_o;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_addr  <= req_addr_i;
            s1_wstrb <= req_wstrb_i;
            s1_wdata <= req_wdata_i;
            s2_addr  <= s1_addr;
            s2_wstrb <= s1_wstrb;
            s2_wdata <= s1_wdata;
        end
    end

    // stage 1 keeps reading while held, so refill data is seen
    assign rd_index_o = s1_addr[OFF_W +: $bits(index_t)];

    assign s2_tag   = s2_addr[`DCACHE_ADDR_W-1 -: TAG_W];
    assign s2_index = s2_addr[OFF_W +: $bits(index_t)];
    assign s2_word  = s2_addr[2 +: $bits(word_sel_t)];
    assign s2_store = |s2_wstrb;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DCACHE_NWAY; w++) begin
            hit_mask[w] = rd_entry_i[w][TAG_W] && (rd_entry_i[w][TAG_W-1:0] == s2_tag);
            if (hit_mask[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // array data belongs to stage 2 only in its first cycle
    assign hit        = |hit_mask;
    assign lookup_act = s2_valid && !miss_pend;
    assign hit_now    = lookup_act && hit;
    assign miss_now   = lookup_act && !hit;

    assign store_be   = line_strb_t'(s2_wstrb) << {s2_word, 2'b00};
    assign store_line = {(`DCACHE_LINE_BYTES/4){s2_wdata}};

    always_comb begin
        for (int b = 0; b < `DCACHE_LINE_BYTES; b++) begin
            refill_merged[b*8 +: 8] = store_be[b] ? store_line[b*8 +: 8]
                                                  : miss.refill_line[b*8 +: 8];
        end
    end

    always_comb begin
        wr.wr_en   = 1'b0;
        wr.way     = hit_way;
        wr.index   = s2_index;
        wr.entry   = {1'b1, 1'b1, s2_tag};
        wr.tag_we  = 1'b0;
        wr.line    = store_line;
        wr.line_be = '0;
        if (miss.refill_valid) begin
            wr.wr_en   = 1'b1;
            wr.way     = miss.refill_way;
            wr.entry   = {s2_store, 1'b1, s2_tag};
            wr.tag_we  = 1'b1;
            wr.line    = refill_merged;
            wr.line_be = '1;
        end else if (hit_now && s2_store) begin
            wr.wr_en   = 1'b1;
            wr.tag_we  = 1'b1;
            wr.line_be = store_be;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            miss_pend <= 1'b0;
        end else if (miss.refill_valid) begin
            miss_pend <= 1'b0;
        end else if (miss_now) begin
            miss_pend <= 1'b1;
        end
    end

    // victim set is captured before stage 1 takes the read port back
    always_ff @(posedge clk) begin
        if (miss_now) begin
            miss.victim_entry <= rd_entry_i;
            miss.victim_line  <= rd_line_i;
        end
    end

    assign miss.miss_valid = miss_pend;
    assign miss.miss_addr  = s2_addr;

    assign sel_line     = miss.refill_valid ? miss.refill_line : rd_line_i[hit_way];
    assign resp_valid_o = hit_now || miss.refill_valid;
    assign resp_rdata_o = s2_store ? '0 : sel_line[{s2_word, 5'b00000} +: 32];

endmodule

`default_nettype wire

/* dcache_store.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_store
    import dcache_pkg::*;
(
    input  wire                            clk,
    input  wire                            rst,
    input  index_t                         rd_index_i,
    array_wr_if.store                      wr,
    output tag_entry_t [`DCACHE_NWAY-1:0]  rd_entry_o,
    output line_t [`DCACHE_NWAY-1:0]       rd_line_o,
    output logic                           init_done_o
);

    logic   init_busy;
    index_t init_idx;

    // sweep one set per cycle to invalid after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            init_busy <= 1'b1;
            init_idx  <= '0;
        end else if (init_busy) begin
            init_idx <= index_t'(init_idx + 1'b1);
            if (init_idx == index_t'(`DCACHE_NSET - 1)) begin
                init_busy <= 1'b0;
            end
        end
    end

    assign init_done_o = ~init_busy;

    for (genvar w = 0; w < `DCACHE_NWAY; w++) begin : g_way
        tag_entry_t tag_mem [`DCACHE_NSET];
        line_t      line_mem [`DCACHE_NSET];
        tag_entry_t entry_q;
        line_t      line_q;
        logic       sel;
        logic       fwd;

        assign sel = wr.wr_en && (wr.way == way_t'(w));
        assign fwd = sel && (wr.index == rd_index_i);

        always_ff @(posedge clk) begin
            if (init_busy) begin
                tag_mem[init_idx] <= '0;
            end else if (sel && wr.tag_we) begin
                tag_mem[wr.index] <= wr.entry;
            end
            for (int b = 0; b < `DCACHE_LINE_BYTES; b++) begin
                if (sel && wr.line_be[b]) begin
                    line_mem[wr.index][b*8 +: 8] <= wr.line[b*8 +: 8];
                end
            end
        end

        // read returns the data written on the same edge
        always_ff @(posedge clk) begin
            entry_q <= (fwd && wr.tag_we) ? wr.entry : tag_mem[rd_index_i];
            for (int b = 0; b < `DCACHE_LINE_BYTES; b++) begin
                line_q[b*8 +: 8] <= (fwd && wr.line_be[b]) ? wr.line[b*8 +: 8]
                                                           : line_mem[rd_index_i][b*8 +: 8];
            end
        end

        assign rd_entry_o[w] = entry_q;
        assign rd_line_o[w]  = line_q;
    end

endmodule

`default_nettype wire

/* dcache_ifs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_macros.svh"

// array write port, takes effect on the next edge
interface array_wr_if import dcache_pkg::*; ();
    logic       wr_en;
    way_t       way;
    index_t     index;
    tag_entry_t entry;
    logic       tag_we;
    line_t      line;
    line_strb_t line_be;

    modport lookup (output wr_en, way, index, entry, tag_we, line, line_be);
    modport store (input wr_en, way, index, entry, tag_we, line, line_be);
endinterface

interface miss_if import dcache_pkg::*; ();
    logic                                miss_valid;
    addr_t                               miss_addr;
    tag_entry_t [`DCACHE_NWAY-1:0]       victim_entry;
    line_t [`DCACHE_NWAY-1:0]            victim_line;
    logic                                refill_valid;
    way_t                                refill_way;
    line_t                               refill_line;

    modport lookup (
        output miss_valid, miss_addr, victim_entry, victim_line,
        input  refill_valid, refill_way, refill_line
    );
    modport miss (
        input  miss_valid, miss_addr, victim_entry, victim_line,
        output refill_valid, refill_way, refill_line
    );
endinterface

`default_nettype wire

/* dcache_pkg.sv */
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [`DCACHE_ADDR_W-1:0] addr_t;
    typedef logic [31:0] word_t;
    // all zeros marks a load
    typedef logic [3:0] strb_t;
    typedef logic [`DCACHE_LINE_BYTES*8-1:0] line_t;
    typedef logic [`DCACHE_LINE_BYTES-1:0] line_strb_t;

    typedef logic [`DCACHE_ADDR_W-$clog2(`DCACHE_NSET)-$clog2(`DCACHE_LINE_BYTES)-1:0] tag_t;
    typedef logic [$clog2(`DCACHE_NSET)-1:0] index_t;
    typedef logic [$clog2(`DCACHE_LINE_BYTES/4)-1:0] word_sel_t;
    typedef logic [$clog2(`DCACHE_NWAY)-1:0] way_t;
    typedef logic [`DCACHE_NWAY-1:0] way_mask_t;

    // {dirty, valid, tag}
    typedef logic [$bits(tag_t)+1:0] tag_entry_t;

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_WB_REQ,
        MS_REFILL_REQ,
        MS_REFILL_WAIT
    } miss_state_t;

endpackage

`default_nettype wire

/* dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// byte address width
`define DCACHE_ADDR_W 32

// bytes per cache line
`define DCACHE_LINE_BYTES 16

// sets per way
`define DCACHE_NSET 64

// associativity
`define DCACHE_NWAY 2

// replacement lfsr width
`define DCACHE_LFSR_W 16

`endif
